// File: mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

  // system sizes
  localparam int NUM_CACHES   = 2;
  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 10;
  localparam int BLOCK_WORDS  = 4;
  localparam int SETS         = 8;
  localparam int MEM_LATENCY  = 4;
  localparam int RESET_STAGES = 3;

  // cache address split, tag | index | offset
  localparam int OFFSET_WIDTH = $clog2(BLOCK_WORDS);
  localparam int INDEX_WIDTH  = $clog2(SETS);
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  // cache id sits above the cache address on the memory side
  localparam int ID_WIDTH       = (NUM_CACHES > 1) ? $clog2(NUM_CACHES) : 1;
  localparam int MEM_ADDR_WIDTH = ID_WIDTH + ADDR_WIDTH;

  // memory latency counter
  localparam int LAT_WIDTH = $clog2(MEM_LATENCY);

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // caches fill only the low ADDR_WIDTH bits, the adapter adds the id
  typedef struct packed {
    logic      write_not_read;
    mem_addr_t addr;
  } dma_pkt_t;

endpackage

`default_nettype wire

// File: vcache_blocking.sv
`timescale 1ns/1ps
`default_nettype none

module vcache_blocking import mem_sys_pkg::*; (
  input  wire logic  core_clk,
  input  wire logic  rst_n_i,

  input  wire logic  req_v_i,
  input  wire logic  req_write_i,
  input  wire addr_t req_addr_i,
  input  wire word_t req_wdata_i,
  output logic       req_yumi_o,
  output logic       resp_v_o,
  output word_t      resp_rdata_o,

  output dma_pkt_t   dma_pkt_o,
  output logic       dma_pkt_v_o,
  input  wire logic  dma_pkt_yumi_i,

  input  wire word_t dma_data_i,
  input  wire logic  dma_data_v_i,
  output logic       dma_data_ready_o,

  output word_t      dma_data_o,
  output logic       dma_data_v_o,
  input  wire logic  dma_data_yumi_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WB_PKT,
    S_WB_DATA,
    S_FILL_PKT,
    S_FILL_DATA,
    S_RESPOND
  } state_e;

  state_e                  state_r;
  logic                    active_r;
  logic [SETS-1:0]         valid_r;
  logic [SETS-1:0]         dirty_r;
  logic [OFFSET_WIDTH-1:0] cnt_r;

  logic                    req_write_r;
  addr_t                   req_addr_r;
  word_t                   req_wdata_r;

  logic [TAG_WIDTH-1:0]    tag_mem [SETS];
  word_t                   data_mem [SETS*BLOCK_WORDS];

  logic [TAG_WIDTH-1:0]    req_tag;
  logic [INDEX_WIDTH-1:0]  req_idx;
  logic [TAG_WIDTH-1:0]    pkt_tag;
  logic                    hit;
  logic                    last_word;
  logic                    word_wr_en;

  assign req_tag   = req_addr_r[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign req_idx   = req_addr_r[OFFSET_WIDTH +: INDEX_WIDTH];
  assign hit       = valid_r[req_idx] && (tag_mem[req_idx] == req_tag);
  assign last_word = (cnt_r == OFFSET_WIDTH'(BLOCK_WORDS-1));

  // store of the front write, on a hit or once the block is in
  assign word_wr_en = req_write_r &&
                      (((state_r == S_LOOKUP) && hit) || (state_r == S_RESPOND));

  // front port
  assign req_yumi_o   = req_v_i && active_r && (state_r == S_IDLE);
  assign resp_v_o     = ((state_r == S_LOOKUP) && hit) || (state_r == S_RESPOND);
  assign resp_rdata_o = data_mem[req_addr_r[OFFSET_WIDTH+INDEX_WIDTH-1:0]];

  // writeback uses the victim tag, fill uses the request tag
  assign pkt_tag                  = (state_r == S_WB_PKT) ? tag_mem[req_idx] : req_tag;
  assign dma_pkt_o.write_not_read = (state_r == S_WB_PKT);
  assign dma_pkt_o.addr           = mem_addr_t'({pkt_tag, req_idx, {OFFSET_WIDTH{1'b0}}});
  assign dma_pkt_v_o              = (state_r == S_WB_PKT) || (state_r == S_FILL_PKT);

  assign dma_data_ready_o = (state_r == S_FILL_DATA);
  assign dma_data_o       = data_mem[{req_idx, cnt_r}];
  assign dma_data_v_o     = (state_r == S_WB_DATA);

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      state_r  <= S_IDLE;
      active_r <= 1'b0;
      valid_r  <= '0;
      dirty_r  <= '0;
      cnt_r    <= '0;
    end else begin
      active_r <= 1'b1;
      case (state_r)
        S_IDLE: begin
          if (req_yumi_o) state_r <= S_LOOKUP;
        end
        S_LOOKUP: begin
          if (hit) begin
            if (req_write_r) dirty_r[req_idx] <= 1'b1;
            state_r <= S_IDLE;
          end else if (valid_r[req_idx] && dirty_r[req_idx]) begin
            state_r <= S_WB_PKT;
          end else begin
            state_r <= S_FILL_PKT;
          end
        end
        S_WB_PKT: begin
          if (dma_pkt_yumi_i) begin
            cnt_r   <= '0;
            state_r <= S_WB_DATA;
          end
        end
        S_WB_DATA: begin
          if (dma_data_yumi_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) state_r <= S_FILL_PKT;
          end
        end
        S_FILL_PKT: begin
          if (dma_pkt_yumi_i) begin
            cnt_r   <= '0;
            state_r <= S_FILL_DATA;
          end
        end
        S_FILL_DATA: begin
          if (dma_data_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              valid_r[req_idx] <= 1'b1;
              dirty_r[req_idx] <= 1'b0;
              state_r          <= S_RESPOND;
            end
          end
        end
        S_RESPOND: begin
          if (req_write_r) dirty_r[req_idx] <= 1'b1;
          state_r <= S_IDLE;
        end
        default: state_r <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_yumi_o) begin
      req_write_r <= req_write_i;
      req_addr_r  <= req_addr_i;
      req_wdata_r <= req_wdata_i;
    end
    if (word_wr_en) begin
      data_mem[req_addr_r[OFFSET_WIDTH+INDEX_WIDTH-1:0]] <= req_wdata_r;
    end
    if ((state_r == S_FILL_DATA) && dma_data_v_i) begin
      data_mem[{req_idx, cnt_r}] <= dma_data_i;
      if (last_word) tag_mem[req_idx] <= req_tag;
    end
  end

endmodule

`default_nettype wire

// File: cache_to_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_to_mem import mem_sys_pkg::*; (
  input  wire logic                       core_clk,
  input  wire logic                       rst_n_i,

  input  wire dma_pkt_t [NUM_CACHES-1:0]  cache_pkt_i,
  input  wire logic [NUM_CACHES-1:0]      cache_pkt_v_i,
  output logic [NUM_CACHES-1:0]           cache_pkt_yumi_o,

  output word_t                           cache_fill_o,
  output logic [NUM_CACHES-1:0]           cache_fill_v_o,
  input  wire logic [NUM_CACHES-1:0]      cache_fill_ready_i,

  input  wire word_t [NUM_CACHES-1:0]     cache_wb_i,
  input  wire logic [NUM_CACHES-1:0]      cache_wb_v_i,
  output logic [NUM_CACHES-1:0]           cache_wb_yumi_o,

  output dma_pkt_t                        mem_pkt_o,
  output logic                            mem_pkt_v_o,
  input  wire logic                       mem_pkt_yumi_i,

  input  wire word_t                      mem_rdata_i,
  input  wire logic                       mem_rdata_v_i,
  output logic                            mem_rdata_ready_o,

  output word_t                           mem_wdata_o,
  output logic                            mem_wdata_v_o,
  input  wire logic                       mem_wdata_yumi_i,

  input  wire logic                       mem_txn_done_i
);

  logic                busy_r;
  // last grant, also the round-robin pointer
  logic [ID_WIDTH-1:0] grant_r;
  logic [ID_WIDTH-1:0] pick_id;
  logic                pick_v;
  dma_pkt_t            pick_pkt;

  // round-robin search starting after the last grant
  always_comb begin
    int cand;
    pick_v  = 1'b0;
    pick_id = '0;
    for (int k = 1; k <= NUM_CACHES; k++) begin
      cand = (int'(grant_r) + k) % NUM_CACHES;
      if (!pick_v && cache_pkt_v_i[cand]) begin
        pick_v  = 1'b1;
        pick_id = ID_WIDTH'(cand);
      end
    end
  end

  assign pick_pkt = cache_pkt_i[pick_id];

  // packet goes out only while no transaction is open
  assign mem_pkt_v_o              = !busy_r && pick_v;
  assign mem_pkt_o.write_not_read = pick_pkt.write_not_read;
  assign mem_pkt_o.addr           = {pick_id, pick_pkt.addr[ADDR_WIDTH-1:0]};

  assign cache_fill_o      = mem_rdata_i;
  assign mem_rdata_ready_o = busy_r && cache_fill_ready_i[grant_r];
  assign mem_wdata_o       = cache_wb_i[grant_r];
  assign mem_wdata_v_o     = busy_r && cache_wb_v_i[grant_r];

  always_comb begin
    logic sel;
    for (int i = 0; i < NUM_CACHES; i++) begin
      sel                 = busy_r && (grant_r == ID_WIDTH'(i));
      cache_fill_v_o[i]   = sel && mem_rdata_v_i;
      cache_wb_yumi_o[i]  = sel && mem_wdata_yumi_i;
      cache_pkt_yumi_o[i] = mem_pkt_yumi_i && (pick_id == ID_WIDTH'(i));
    end
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      busy_r  <= 1'b0;
      grant_r <= ID_WIDTH'(NUM_CACHES-1);
    end else if (mem_pkt_v_o && mem_pkt_yumi_i) begin
      busy_r  <= 1'b1;
      grant_r <= pick_id;
    end else if (mem_txn_done_i) begin
      busy_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: block_mem.sv
`timescale 1ns/1ps
`default_nettype none

module block_mem import mem_sys_pkg::*; (
  input  wire logic     core_clk,
  input  wire logic     rst_n_i,

  input  wire dma_pkt_t pkt_i,
  input  wire logic     pkt_v_i,
  output logic          pkt_yumi_o,

  output word_t         rdata_o,
  output logic          rdata_v_o,
  input  wire logic     rdata_ready_i,

  input  wire word_t    wdata_i,
  input  wire logic     wdata_v_i,
  output logic          wdata_yumi_o,

  output logic          txn_done_o
);

  typedef enum logic [1:0] {M_IDLE, M_WAIT, M_READ, M_WRITE} state_e;

  state_e                  state_r;
  logic [LAT_WIDTH-1:0]    lat_cnt_r;
  logic [OFFSET_WIDTH-1:0] word_cnt_r;
  mem_addr_t               base_r;
  word_t                   mem [2**MEM_ADDR_WIDTH];

  mem_addr_t               word_addr;
  logic                    last_word;

  assign word_addr = {base_r[MEM_ADDR_WIDTH-1:OFFSET_WIDTH], word_cnt_r};
  assign last_word = (word_cnt_r == OFFSET_WIDTH'(BLOCK_WORDS-1));

  assign pkt_yumi_o   = pkt_v_i && (state_r == M_IDLE);
  assign rdata_v_o    = (state_r == M_READ);
  assign rdata_o      = mem[word_addr];
  assign wdata_yumi_o = wdata_v_i && (state_r == M_WRITE);
  assign txn_done_o   = last_word && ((rdata_v_o && rdata_ready_i) || wdata_yumi_o);

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      state_r    <= M_IDLE;
      lat_cnt_r  <= '0;
      word_cnt_r <= '0;
    end else begin
      case (state_r)
        M_IDLE: begin
          if (pkt_yumi_o) begin
            word_cnt_r <= '0;
            // wait states fill the gap up to the first read word
            lat_cnt_r  <= LAT_WIDTH'(MEM_LATENCY-2);
            state_r    <= pkt_i.write_not_read ? M_WRITE : M_WAIT;
          end
        end
        M_WAIT: begin
          if (lat_cnt_r == '0) state_r <= M_READ;
          else lat_cnt_r <= lat_cnt_r - 1'b1;
        end
        M_READ: begin
          if (rdata_ready_i) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (last_word) state_r <= M_IDLE;
          end
        end
        M_WRITE: begin
          if (wdata_yumi_o) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (last_word) state_r <= M_IDLE;
          end
        end
        default: state_r <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (pkt_yumi_o) base_r <= pkt_i.addr;
    if (wdata_yumi_o) mem[word_addr] <= wdata_i;
  end

endmodule

`default_nettype wire

// File: mem_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_top import mem_sys_pkg::*; (
  input  wire logic                   core_clk,
  input  wire logic                   rst_n_i,

  input  wire logic [NUM_CACHES-1:0]  req_v_i,
  input  wire logic [NUM_CACHES-1:0]  req_write_i,
  input  wire addr_t [NUM_CACHES-1:0] req_addr_i,
  input  wire word_t [NUM_CACHES-1:0] req_wdata_i,
  output logic [NUM_CACHES-1:0]       req_yumi_o,
  output logic [NUM_CACHES-1:0]       resp_v_o,
  output word_t [NUM_CACHES-1:0]      resp_rdata_o
);

  // reset passes through the same flop depth as the full chip
  logic [RESET_STAGES-1:0] rst_n_r;
  logic                    rst_n_piped;

  always_ff @(posedge core_clk) begin
    rst_n_r <= {rst_n_r[RESET_STAGES-2:0], rst_n_i};
  end

  assign rst_n_piped = rst_n_r[RESET_STAGES-1];

  dma_pkt_t [NUM_CACHES-1:0] dma_pkt;
  logic [NUM_CACHES-1:0]     dma_pkt_v;
  logic [NUM_CACHES-1:0]     dma_pkt_yumi;
  word_t                     dma_fill;
  logic [NUM_CACHES-1:0]     dma_fill_v;
  logic [NUM_CACHES-1:0]     dma_fill_ready;
  word_t [NUM_CACHES-1:0]    dma_wb;
  logic [NUM_CACHES-1:0]     dma_wb_v;
  logic [NUM_CACHES-1:0]     dma_wb_yumi;

  dma_pkt_t                  mem_pkt;
  logic                      mem_pkt_v;
  logic                      mem_pkt_yumi;
  word_t                     mem_rdata;
  logic                      mem_rdata_v;
  logic                      mem_rdata_ready;
  word_t                     mem_wdata;
  logic                      mem_wdata_v;
  logic                      mem_wdata_yumi;
  logic                      mem_txn_done;

  for (genvar i = 0; i < NUM_CACHES; i++) begin : g_cache
    vcache_blocking u_vcache (
      .core_clk         (core_clk),
      .rst_n_i          (rst_n_piped),
      .req_v_i          (req_v_i[i]),
      .req_write_i      (req_write_i[i]),
      .req_addr_i       (req_addr_i[i]),
      .req_wdata_i      (req_wdata_i[i]),
      .req_yumi_o       (req_yumi_o[i]),
      .resp_v_o         (resp_v_o[i]),
      .resp_rdata_o     (resp_rdata_o[i]),
      .dma_pkt_o        (dma_pkt[i]),
      .dma_pkt_v_o      (dma_pkt_v[i]),
      .dma_pkt_yumi_i   (dma_pkt_yumi[i]),
      .dma_data_i       (dma_fill),
      .dma_data_v_i     (dma_fill_v[i]),
      .dma_data_ready_o (dma_fill_ready[i]),
      .dma_data_o       (dma_wb[i]),
      .dma_data_v_o     (dma_wb_v[i]),
      .dma_data_yumi_i  (dma_wb_yumi[i])
    );
  end

  cache_to_mem u_cache_to_mem (
    .core_clk           (core_clk),
    .rst_n_i            (rst_n_piped),
    .cache_pkt_i        (dma_pkt),
    .cache_pkt_v_i      (dma_pkt_v),
    .cache_pkt_yumi_o   (dma_pkt_yumi),
    .cache_fill_o       (dma_fill),
    .cache_fill_v_o     (dma_fill_v),
    .cache_fill_ready_i (dma_fill_ready),
    .cache_wb_i         (dma_wb),
    .cache_wb_v_i       (dma_wb_v),
    .cache_wb_yumi_o    (dma_wb_yumi),
    .mem_pkt_o          (mem_pkt),
    .mem_pkt_v_o        (mem_pkt_v),
    .mem_pkt_yumi_i     (mem_pkt_yumi),
    .mem_rdata_i        (mem_rdata),
    .mem_rdata_v_i      (mem_rdata_v),
    .mem_rdata_ready_o  (mem_rdata_ready),
    .mem_wdata_o        (mem_wdata),
    .mem_wdata_v_o      (mem_wdata_v),
    .mem_wdata_yumi_i   (mem_wdata_yumi),
    .mem_txn_done_i     (mem_txn_done)
  );

  block_mem u_block_mem (
    .core_clk      (core_clk),
    .rst_n_i       (rst_n_piped),
    .pkt_i         (mem_pkt),
    .pkt_v_i       (mem_pkt_v),
    .pkt_yumi_o    (mem_pkt_yumi),
    .rdata_o       (mem_rdata),
    .rdata_v_o     (mem_rdata_v),
    .rdata_ready_i (mem_rdata_ready),
    .wdata_i       (mem_wdata),
    .wdata_v_i     (mem_wdata_v),
    .wdata_yumi_o  (mem_wdata_yumi),
    .txn_done_o    (mem_txn_done)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 8
) (
  output logic core_clk,
  output logic rst_n_o
);

  initial begin
    core_clk = 1'b0;
    forever #HALF_PERIOD core_clk = ~core_clk;
  end

  // release on a falling edge, like the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge core_clk);
    @(negedge core_clk);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: mem_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb import mem_sys_pkg::*; ();

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 8;
  localparam int WAIT_LIMIT    = 300;
  localparam int OPS_PER_CACHE = 100;

  logic                   core_clk;
  logic                   rst_n;
  logic [NUM_CACHES-1:0]  req_v;
  logic [NUM_CACHES-1:0]  req_write;
  addr_t [NUM_CACHES-1:0] req_addr;
  word_t [NUM_CACHES-1:0] req_wdata;
  logic [NUM_CACHES-1:0]  req_yumi;
  logic [NUM_CACHES-1:0]  resp_v;
  word_t [NUM_CACHES-1:0] resp_rdata;

  // reference state with one private region per cache
  word_t model [NUM_CACHES][2**ADDR_WIDTH];
  logic  monitor_on;
  logic  pending [NUM_CACHES];
  logic  pend_read [NUM_CACHES];
  word_t exp_data [NUM_CACHES];
  int    resp_cnt [NUM_CACHES];
  time   acc_time [NUM_CACHES];
  time   resp_time [NUM_CACHES];
  int    errors;

  tb_clk_gen #(.HALF_PERIOD(CLK_PERIOD/2), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
    .core_clk (core_clk),
    .rst_n_o  (rst_n)
  );

  mem_sys_top dut0 (
    .core_clk     (core_clk),
    .rst_n_i      (rst_n),
    .req_v_i      (req_v),
    .req_write_i  (req_write),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_yumi_o   (req_yumi),
    .resp_v_o     (resp_v),
    .resp_rdata_o (resp_rdata)
  );

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: %s is %0h, expected %0h",
                               $time, name, got, exp));
    end
  endtask

  function automatic word_t expected_word(input int c, input addr_t a);
    return model[c][a];
  endfunction

  function automatic addr_t make_addr(input int tag, input int idx, input int off);
    return addr_t'((tag << (INDEX_WIDTH + OFFSET_WIDTH)) | (idx << OFFSET_WIDTH) | off);
  endfunction

  // sampled at the rising edge before the flops update
  always @(posedge core_clk) begin
    if (monitor_on) begin
      for (int c = 0; c < NUM_CACHES; c++) begin
        if (resp_v[c] === 1'b1) begin
          if (!pending[c]) begin
            report_failure($sformatf("cache %0d responded with no request open", c));
          end else begin
            if (pend_read[c]) begin
              check_value($sformatf("resp_rdata_o[%0d]", c), resp_rdata[c], exp_data[c]);
            end
            pending[c]   = 1'b0;
            resp_cnt[c]  = resp_cnt[c] + 1;
            resp_time[c] = $time;
          end
        end
        if (req_v[c] && (req_yumi[c] === 1'b1)) begin
          if (pending[c]) begin
            report_failure($sformatf("cache %0d took a request before responding", c));
          end else begin
            pending[c]   = 1'b1;
            pend_read[c] = !req_write[c];
            acc_time[c]  = $time;
            if (req_write[c]) model[c][req_addr[c]] = req_wdata[c];
            else exp_data[c] = expected_word(c, req_addr[c]);
          end
        end
      end
    end
  end

  // issues one request and waits for acceptance and for its response
  task automatic do_req(input int c, input logic wr, input addr_t a, input word_t d,
                        output int lat);
    int t;
    int start_cnt;
    lat = 0;
    @(negedge core_clk);
    req_v[c]     = 1'b1;
    req_write[c] = wr;
    req_addr[c]  = a;
    req_wdata[c] = d;
    start_cnt    = resp_cnt[c];
    t = 0;
    @(posedge core_clk);
    while ((req_yumi[c] !== 1'b1) && (t < WAIT_LIMIT)) begin
      @(posedge core_clk);
      t++;
    end
    if (req_yumi[c] !== 1'b1) begin
      report_failure($sformatf("timeout: cache %0d never took the request", c));
    end else begin
      @(negedge core_clk);
      req_v[c] = 1'b0;
      t = 0;
      while ((resp_cnt[c] == start_cnt) && (t < WAIT_LIMIT)) begin
        @(negedge core_clk);
        t++;
      end
      if (resp_cnt[c] == start_cnt) begin
        report_failure($sformatf("timeout: cache %0d never responded", c));
      end else begin
        lat = int'((resp_time[c] - acc_time[c]) / CLK_PERIOD);
      end
    end
  endtask

  task automatic random_traffic(input int c, input int n);
    addr_t pool [$];
    addr_t a;
    logic  wr;
    int    lat;
    for (int i = 0; i < n; i++) begin
      wr = (pool.size() == 0) || ($urandom % 2 == 0);
      if (wr) begin
        a = addr_t'($urandom);
        do_req(c, 1'b1, a, $urandom, lat);
        pool.push_back(a);
      end else begin
        a = pool[$urandom % pool.size()];
        do_req(c, 1'b0, a, '0, lat);
      end
    end
  endtask

  initial begin
    int seed;
    int lat;
    $timeformat(-9, 0, " ns", 0);
    seed       = $urandom(30);
    req_v      = '0;
    req_write  = '0;
    req_addr   = '0;
    req_wdata  = '0;
    monitor_on = 1'b0;
    errors     = 0;
    for (int c = 0; c < NUM_CACHES; c++) begin
      pending[c]   = 1'b0;
      pend_read[c] = 1'b0;
      resp_cnt[c]  = 0;
    end

    // caches are reset from falling edge RESET_STAGES+1 on
    for (int n = 1; n <= RESET_CYCLES + RESET_STAGES; n++) begin
      @(negedge core_clk);
      if (n >= RESET_STAGES + 1) begin
        check_value("req_yumi_o", req_yumi, '0);
        check_value("resp_v_o", resp_v, '0);
        monitor_on = 1'b1;
        req_v = (n == RESET_CYCLES + RESET_STAGES) ? '0 : '1;
      end
    end

    // write and read back twice so the second read hits
    do_req(0, 1'b1, make_addr(1, 2, 3), 32'h1234_5678, lat);
    do_req(0, 1'b0, make_addr(1, 2, 3), '0, lat);
    do_req(0, 1'b0, make_addr(1, 2, 3), '0, lat);
    check_value("read hit latency", lat, 1);

    // same index with different tags
    for (int k = 0; k < 4; k++) do_req(0, 1'b1, make_addr(k * 3, 3, 1), $urandom, lat);
    for (int k = 0; k < 4; k++) do_req(0, 1'b0, make_addr(k * 3, 3, 1), '0, lat);

    // same addresses on both caches are evicted then refilled from memory
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < NUM_CACHES; c++) do_req(c, 1'b1, make_addr(20, k, 2), $urandom, lat);
    end
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < NUM_CACHES; c++) do_req(c, 1'b1, make_addr(21, k, 2), $urandom, lat);
    end
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < NUM_CACHES; c++) do_req(c, 1'b0, make_addr(20, k, 2), '0, lat);
    end

    fork
      random_traffic(0, OPS_PER_CACHE);
      random_traffic(1, OPS_PER_CACHE);
    join

    // idle cycles to catch stray responses
    repeat (20) @(negedge core_clk);

    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_sys.f
mem_sys_pkg.sv
vcache_blocking.sv
cache_to_mem.sv
block_mem.sv
mem_sys_top.sv
tb_clk_gen.sv
mem_sys_tb.sv

// File: Bender.yml
package:
  name: mem_sys

sources:
  - mem_sys_pkg.sv
  - vcache_blocking.sv
  - cache_to_mem.sv
  - block_mem.sv
  - mem_sys_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - mem_sys_tb.sv
